//--- include/trace_settings.svh
// Widths shared by the trace unit; the tag width must keep 2**TAG_W well above five in flight
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Field widths
////////////////////////////////////////////////////////////////////////////

`define TRACE_TAG_W   6    // 64 tags in the fetch log
`define TRACE_CYCLE_W 16   // Cycle stamp and latency, wraps
`define TRACE_PC_W    32   // Core program counter

// Stall count saturates at all ones
`define TRACE_STALL_W 4

// Retired and flushed running totals, wrap silently
`define TRACE_TOTAL_W 16

`endif

//--- sources.f
+incdir+include
src/trace_pkg.sv
src/stage_tracker.sv
src/fetch_log.sv
src/stall_accum.sv
src/retire_report.sv
src/pipe_trace_top.sv
tb/tb_pipe_trace.sv

//--- src/fetch_log.sv
// Fetch log indexed by tag; an entry is only good while fewer than 64 fetches are newer
`timescale 1ns/1ps

module fetch_log import trace_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   fetch_accept,     // Entry has just landed in fetch
    input  tag_t   fetch_tag,
    input  pc_t    fetch_pc,         // Core PC, valid with fetch_valid
    input  tag_t   wb_tag,
    output cycle_t now_cycle,
    output pc_t    wb_pc,
    output cycle_t wb_fetch_cycle
);

`include "trace_settings.svh"

    cycle_t cycle_cnt;
    pc_t    pc_dly;          // PC of the fetch that entered at the last edge

    pc_t    pc_mem  [0:(1 << `TRACE_TAG_W)-1];
    cycle_t cyc_mem [0:(1 << `TRACE_TAG_W)-1];

    ////////////////////////////////////////////////////////////////////////////
    // Free-running cycle counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + cycle_t'(1);
        end
    end

    assign now_cycle = cycle_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Tag-indexed log
    ////////////////////////////////////////////////////////////////////////////

    // The strobe comes one cycle after the core offered the PC
    always_ff @(posedge clk) begin
        pc_dly <= fetch_pc;
    end

    always_ff @(posedge clk) begin
        if (fetch_accept) begin
            pc_mem[fetch_tag]  <= pc_dly;
            cyc_mem[fetch_tag] <= cycle_cnt;   // Stamp of the first cycle in fetch
        end
    end

    // Combinational read for the write-back entry
    assign wb_pc          = pc_mem[wb_tag];
    assign wb_fetch_cycle = cyc_mem[wb_tag];

endmodule

//--- src/pipe_trace_top.sv
// Trace unit top; sees only the core's fetch, stall and flush, so it trusts them to be exact
`timescale 1ns/1ps

module pipe_trace_top import trace_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_valid,
    input  pc_t        fetch_pc,
    input  logic       stall,
    input  logic       flush,
    output logic       retire_valid,
    output tag_t       retire_tag,
    output pc_t        retire_pc,
    output cycle_t     retire_latency,
    output stall_cnt_t retire_stalls,
    output total_t     retired_total,
    output total_t     flushed_total
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////////////////////////////////////////

    logic       fetch_accept;
    tag_t       fetch_tag;
    logic       front_hold;
    kill_cnt_t  kill_num;
    logic       wb_valid;
    tag_t       wb_tag;

    cycle_t     now_cycle;
    pc_t        wb_pc;
    cycle_t     wb_fetch_cycle;
    stall_cnt_t wb_stall_count;

    ////////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////////

    stage_tracker tracker_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .stall        (stall),
        .flush        (flush),
        .fetch_accept (fetch_accept),
        .fetch_tag    (fetch_tag),
        .front_hold   (front_hold),
        .kill_num     (kill_num),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag)
    );

    fetch_log log_i (
        .clk            (clk),
        .rst            (rst),
        .fetch_accept   (fetch_accept),
        .fetch_tag      (fetch_tag),
        .fetch_pc       (fetch_pc),
        .wb_tag         (wb_tag),
        .now_cycle      (now_cycle),
        .wb_pc          (wb_pc),
        .wb_fetch_cycle (wb_fetch_cycle)
    );

    // Shadows the tracker's stage shifts
    stall_accum stall_i (
        .clk            (clk),
        .rst            (rst),
        .fetch_accept   (fetch_accept),
        .front_hold     (front_hold),
        .wb_stall_count (wb_stall_count)
    );

    retire_report report_i (
        .clk            (clk),
        .rst            (rst),
        .wb_valid       (wb_valid),
        .wb_tag         (wb_tag),
        .wb_pc          (wb_pc),
        .wb_fetch_cycle (wb_fetch_cycle),
        .wb_stall_count (wb_stall_count),
        .now_cycle      (now_cycle),
        .kill_num       (kill_num),
        .retire_valid   (retire_valid),
        .retire_tag     (retire_tag),
        .retire_pc      (retire_pc),
        .retire_latency (retire_latency),
        .retire_stalls  (retire_stalls),
        .retired_total  (retired_total),
        .flushed_total  (flushed_total)
    );

endmodule

//--- src/retire_report.sv
// Retire record one cycle after write-back; latency and totals wrap at their widths
`timescale 1ns/1ps

module retire_report import trace_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wb_valid,
    input  tag_t       wb_tag,
    input  pc_t        wb_pc,
    input  cycle_t     wb_fetch_cycle,
    input  stall_cnt_t wb_stall_count,
    input  cycle_t     now_cycle,
    input  kill_cnt_t  kill_num,        // Entries killed by this cycle's flush
    output logic       retire_valid,
    output tag_t       retire_tag,
    output pc_t        retire_pc,
    output cycle_t     retire_latency,
    output stall_cnt_t retire_stalls,
    output total_t     retired_total,
    output total_t     flushed_total
);

    cycle_t latency_now;

    // Counts the retire cycle itself, modulo the counter width
    assign latency_now = now_cycle + cycle_t'(1) - wb_fetch_cycle;

    ////////////////////////////////////////////////////////////////////////////
    // Strobe and totals
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid  <= 1'b0;
            retired_total <= '0;
            flushed_total <= '0;
        end else begin
            retire_valid  <= wb_valid;
            flushed_total <= flushed_total + total_t'(kill_num);
            if (wb_valid) begin
                retired_total <= retired_total + total_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Record fields
    ////////////////////////////////////////////////////////////////////////////

    // Held between retires
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            retire_tag     <= wb_tag;
            retire_pc      <= wb_pc;
            retire_latency <= latency_now;
            retire_stalls  <= wb_stall_count;
        end
    end

endmodule

//--- src/stage_tracker.sv
// Mirrors a five-stage in-order core; assumes flush kills fetch and decode and stall holds both
`timescale 1ns/1ps

module stage_tracker import trace_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      fetch_valid,    // Core fetch strobe
    input  logic      stall,          // Core front-end hold
    input  logic      flush,          // Core front-end kill
    output logic      fetch_accept,   // High in the first cycle an entry sits in fetch
    output tag_t      fetch_tag,
    output logic      front_hold,
    output kill_cnt_t kill_num,
    output logic      wb_valid,
    output tag_t      wb_tag
);

    ////////////////////////////////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////////////////////////////////

    logic f_valid;
    logic d_valid;
    logic e_valid;
    logic m_valid;

    tag_t f_tag;
    tag_t d_tag;
    tag_t e_tag;
    tag_t m_tag;

    tag_t next_tag;      // Tag for the next accepted fetch
    logic take_fetch;
    logic kill_f;
    logic kill_d;

    ////////////////////////////////////////////////////////////////////////////
    // Stall and flush decode
    ////////////////////////////////////////////////////////////////////////////

    // Flush wins over stall
    assign front_hold = stall & ~flush;
    assign take_fetch = fetch_valid & ~stall & ~flush;   // No tag spent on held fetches

    assign kill_f   = flush & f_valid;
    assign kill_d   = flush & d_valid;
    assign kill_num = {1'b0, kill_f} + {1'b0, kill_d};

    assign fetch_tag = f_tag;

    ////////////////////////////////////////////////////////////////////////////
    // Valid bits and tag counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            f_valid      <= 1'b0;
            d_valid      <= 1'b0;
            e_valid      <= 1'b0;
            m_valid      <= 1'b0;
            wb_valid     <= 1'b0;
            next_tag     <= '0;
            fetch_accept <= 1'b0;
        end else begin
            fetch_accept <= take_fetch;
            if (take_fetch) begin
                next_tag <= next_tag + tag_t'(1);   // Wraps after 64
            end

            // Back end never waits
            m_valid  <= e_valid;
            wb_valid <= m_valid;

            if (flush) begin
                f_valid <= 1'b0;
                d_valid <= 1'b0;
                e_valid <= 1'b0;     // Decode entry killed, nothing moves on
            end else if (stall) begin
                e_valid <= 1'b0;     // Bubble behind the held front
            end else begin
                f_valid <= fetch_valid;
                d_valid <= f_valid;
                e_valid <= d_valid;
            end
        end
    end

    // Tags ride along with the valid bits
    always_ff @(posedge clk) begin
        m_tag  <= e_tag;
        wb_tag <= m_tag;
        if (!front_hold) begin
            f_tag <= next_tag;
            d_tag <= f_tag;
            e_tag <= d_tag;
        end
    end

endmodule

//--- src/stall_accum.sv
// Stall counts per stage, kept in step with the tracker; counts saturate at 15
`timescale 1ns/1ps

module stall_accum import trace_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_accept,    // Fresh entry in fetch this cycle
    input  logic       front_hold,      // Stall without flush
    output stall_cnt_t wb_stall_count
);

    stall_cnt_t cnt_f;
    stall_cnt_t cnt_d;
    stall_cnt_t cnt_e;
    stall_cnt_t cnt_m;
    stall_cnt_t cnt_w;
    stall_cnt_t base_f;

    function automatic stall_cnt_t sat_inc(input stall_cnt_t v);
        if (&v) begin
            return v;
        end
        return v + stall_cnt_t'(1);
    endfunction

    // A new entry in fetch starts counting from zero
    assign base_f = fetch_accept ? '0 : cnt_f;

    ////////////////////////////////////////////////////////////////////////////
    // Counter pipeline
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_f <= '0;
            cnt_d <= '0;
            cnt_e <= '0;
            cnt_m <= '0;
            cnt_w <= '0;
        end else begin
            cnt_m <= cnt_e;
            cnt_w <= cnt_m;
            if (front_hold) begin
                cnt_f <= sat_inc(base_f);    // Held in fetch
                cnt_d <= sat_inc(cnt_d);     // Held in decode
                cnt_e <= '0;                 // Bubble
            end else begin
                cnt_f <= '0;
                cnt_d <= cnt_f;
                cnt_e <= cnt_d;
            end
        end
    end

    assign wb_stall_count = cnt_w;

endmodule

//--- src/trace_pkg.sv
// Trace unit types; widths come from the settings header, kill count fixed at two entries
package trace_pkg;

`include "trace_settings.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`TRACE_TAG_W-1:0]   tag_t;        // Instruction tag
    typedef logic [`TRACE_CYCLE_W-1:0] cycle_t;      // Cycle stamp or latency
    typedef logic [`TRACE_PC_W-1:0]    pc_t;         // Program counter
    typedef logic [`TRACE_STALL_W-1:0] stall_cnt_t;  // Saturating stall count
    typedef logic [`TRACE_TOTAL_W-1:0] total_t;      // Running total

    // Only fetch and decode can be killed, so 0 to 2
    typedef logic [1:0] kill_cnt_t;

endpackage

//--- tb/tb_pipe_trace.sv
// Testbench for the trace unit; the model samples inputs at each edge and assumes 5 stages
`timescale 1ns/1ps

module tb_pipe_trace import trace_pkg::*; ();

`include "trace_settings.svh"

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 2;
    localparam int RANDOM_CYCLES  = 400;
    localparam int LEN_BASIC      = 40;
    localparam int LEN_STALL      = 80;
    localparam int LEN_FLUSH      = 40;
    localparam int LEN_BOTH       = 40;
    localparam int LEN_RANDOM     = RANDOM_CYCLES + 40;
    localparam int RUN_CYCLES     = RESET_CYCLES + LEN_BASIC + LEN_STALL + LEN_FLUSH
                                    + LEN_BOTH + LEN_RANDOM;
    localparam int STALL_MAX      = (1 << `TRACE_STALL_W) - 1;

    logic       clk = 1'b0;
    logic       rst;
    logic       fetch_valid;
    pc_t        fetch_pc;
    logic       stall;
    logic       flush;
    logic       retire_valid;
    tag_t       retire_tag;
    pc_t        retire_pc;
    cycle_t     retire_latency;
    stall_cnt_t retire_stalls;
    total_t     retired_total;
    total_t     flushed_total;

    integer seed = 61821;
    string  test_name;
    pc_t    next_pc;

    // Reference pipeline, slot 0 is fetch and slot 4 is write-back
    logic   slot_valid  [0:4];
    tag_t   slot_tag    [0:4];
    pc_t    slot_pc     [0:4];
    int     slot_stalls [0:4];
    tag_t   model_tag;
    int     model_retired;
    int     model_flushed;
    int     model_accepted;

    // Record expected in the cycle after the current edge
    logic   exp_valid = 1'b0;
    tag_t   exp_tag;
    pc_t    exp_pc;
    int     exp_stalls;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pipe_trace_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .stall          (stall),
        .flush          (flush),
        .retire_valid   (retire_valid),
        .retire_tag     (retire_tag),
        .retire_pc      (retire_pc),
        .retire_latency (retire_latency),
        .retire_stalls  (retire_stalls),
        .retired_total  (retired_total),
        .flushed_total  (flushed_total)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic report_problem(input string msg);
        $display("error in %s: %s", test_name, msg);
        stop_with_failure();
    endtask

    task automatic check_tag(input string what, input tag_t exp, input tag_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_pc(input string what, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_cycle(input string what, input cycle_t exp, input cycle_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_stall(input string what, input stall_cnt_t exp, input stall_cnt_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_total(input string what, input total_t exp, input total_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Five stages plus every cycle spent held in fetch or decode
    function automatic cycle_t expected_latency(input int stalls);
        return cycle_t'(5 + stalls);
    endfunction

    function automatic void move_slot(input int dst, input int src);
        slot_valid[dst]  = slot_valid[src];
        slot_tag[dst]    = slot_tag[src];
        slot_pc[dst]     = slot_pc[src];
        slot_stalls[dst] = slot_stalls[src];
    endfunction

    function automatic logic model_busy();
        return slot_valid[0] | slot_valid[1] | slot_valid[2] | slot_valid[3]
               | slot_valid[4] | exp_valid;
    endfunction

    always @(posedge clk) begin : ref_model
        exp_valid = 1'b0;
        if (rst) begin
            for (int s = 0; s < 5; s++) begin
                slot_valid[s] = 1'b0;
            end
            model_tag      = '0;
            model_retired  = 0;
            model_flushed  = 0;
            model_accepted = 0;
        end else begin
            if (slot_valid[4]) begin              // Leaves write-back at this edge
                exp_valid  = 1'b1;
                exp_tag    = slot_tag[4];
                exp_pc     = slot_pc[4];
                exp_stalls = slot_stalls[4];
                model_retired++;
            end
            if (flush) begin
                model_flushed += int'(slot_valid[0]) + int'(slot_valid[1]);
            end
            move_slot(4, 3);
            move_slot(3, 2);
            if (flush) begin
                slot_valid[0] = 1'b0;
                slot_valid[1] = 1'b0;
                slot_valid[2] = 1'b0;
            end else if (stall) begin
                slot_valid[2] = 1'b0;             // Bubble into execute
                slot_stalls[0]++;
                slot_stalls[1]++;
            end else begin
                move_slot(2, 1);
                move_slot(1, 0);
                slot_valid[0]  = fetch_valid;
                slot_tag[0]    = model_tag;
                slot_pc[0]     = fetch_pc;
                slot_stalls[0] = 0;
                if (fetch_valid) begin
                    model_tag = model_tag + tag_t'(1);
                    model_accepted++;
                end
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin : retire_checker
        stall_cnt_t exp_sat;
        if (!rst) begin
            exp_sat = (exp_stalls > STALL_MAX) ? stall_cnt_t'(STALL_MAX)
                                               : stall_cnt_t'(exp_stalls);
            if (retire_valid !== exp_valid) begin
                if (retire_valid === 1'b1) begin
                    report_problem("a retire record appeared that the model did not predict");
                end else begin
                    report_problem("the model predicted a retire but retire_valid was not high");
                end
            end
            if (exp_valid) begin
                check_tag("retire_tag", exp_tag, retire_tag);
                check_pc("retire_pc", exp_pc, retire_pc);
                check_cycle("retire_latency", expected_latency(exp_stalls), retire_latency);
                check_stall("retire_stalls", exp_sat, retire_stalls);
            end
            check_total("retired_total", total_t'(model_retired), retired_total);
            check_total("flushed_total", total_t'(model_flushed), flushed_total);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_cycle(input logic fv, input pc_t pc, input logic st, input logic fl);
        @(posedge clk);
        #1;
        fetch_valid = fv;
        fetch_pc    = pc;
        stall       = st;
        flush       = fl;
    endtask

    task automatic fetch_run(input int n);
        repeat (n) begin
            drive_cycle(1'b1, next_pc, 1'b0, 1'b0);
            next_pc = next_pc + pc_t'(4);
        end
    endtask

    // Fetch stays high with a stray PC, which must not take a tag
    task automatic hold_run(input int n, input logic with_flush);
        repeat (n) begin
            drive_cycle(1'b1, next_pc ^ pc_t'(32'hdead_0000), 1'b1, with_flush);
        end
    endtask

    task automatic drain_pipe();
        drive_cycle(1'b0, '0, 1'b0, 1'b0);
        do begin
            @(negedge clk);
        end while (model_busy());
        repeat (2) @(negedge clk);
    endtask

    task automatic check_deltas(input int ret_mark, input int fl_mark,
                                input int ret_add, input int fl_add);
        check_total("retired in test", total_t'(ret_mark + ret_add), retired_total);
        check_total("killed in test", total_t'(fl_mark + fl_add), flushed_total);
    endtask

    task automatic run_random(input int cycles);
        int   r_fetch;
        int   r_stall;
        int   r_flush;
        pc_t  pc;
        for (int i = 0; i < cycles; i++) begin
            r_fetch = $unsigned($random(seed)) % 100;
            r_stall = $unsigned($random(seed)) % 100;
            r_flush = $unsigned($random(seed)) % 100;
            pc      = $random(seed);
            drive_cycle(r_fetch < 60, {pc[31:2], 2'b00}, r_stall < 15, r_flush < 8);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        #((RUN_CYCLES + 20) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", RUN_CYCLES + 20);
        stop_with_failure();
    end

    initial begin : main_seq
        int ret_mark;
        int fl_mark;
        int acc_mark;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        next_pc     = pc_t'(32'h0000_1000);
        test_name   = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "back_to_back";
        fetch_run(12);
        drain_pipe();
        check_deltas(0, 0, 12, 0);

        test_name = "stall";
        ret_mark  = model_retired;
        fl_mark   = model_flushed;
        fetch_run(6);
        hold_run(3, 1'b0);
        fetch_run(4);
        hold_run(17, 1'b0);    // Longer than the stall count can hold
        fetch_run(3);
        drain_pipe();
        check_deltas(ret_mark, fl_mark, 13, 0);

        test_name = "flush";
        ret_mark  = model_retired;
        fl_mark   = model_flushed;
        fetch_run(5);
        drive_cycle(1'b1, next_pc, 1'b0, 1'b1);
        fetch_run(4);
        drain_pipe();
        check_deltas(ret_mark, fl_mark, 7, 2);

        test_name = "flush_with_stall";
        ret_mark  = model_retired;
        fl_mark   = model_flushed;
        fetch_run(4);
        hold_run(2, 1'b1);     // Second cycle finds the front empty
        fetch_run(3);
        hold_run(2, 1'b0);
        fetch_run(2);
        drain_pipe();
        check_deltas(ret_mark, fl_mark, 7, 2);

        test_name = "random_mix";
        acc_mark  = model_accepted;
        run_random(RANDOM_CYCLES);
        drain_pipe();
        if (model_accepted - acc_mark <= 64) begin
            report_problem("the random run accepted too few fetches to wrap the tag");
        end
        check_total("retired plus killed", total_t'(model_accepted),
                    retired_total + flushed_total);

        $display("RESULT: PASS");
        $finish;
    end

endmodule
